// ==== hw/tl_defines.svh ====
`ifndef TL_DEFINES_SVH
`define TL_DEFINES_SVH

// Data and address width
`define TL_WORD_W 32

// Register-file write address
`define TL_REG_W 5

// Byte offset inside a 16-byte line
`define TL_OFFSET_W 4

// Byte offset inside a word, ignored for word matching
`define TL_WORD_OFFSET_W 2

// Line index and number of lines in the tag array
`define TL_INDEX_W 3
`define TL_LINES (1 << `TL_INDEX_W)

// Tag holds every address bit above index and offset
`define TL_TAG_W (`TL_WORD_W - `TL_INDEX_W - `TL_OFFSET_W)

// Store buffer geometry
`define TL_SB_DEPTH 2
`define TL_SB_PTR_W 1

`endif

// ==== hw/tl_pkg.sv ====
`include "tl_defines.svh"

package tl_pkg;

    // Tag-lookup stage FSM
    // Both hazard states hold the pipeline
    typedef enum logic [1:0] {
        TL_IDLE           = 2'd0,
        HAZARD_DC_MISS    = 2'd1,
        HAZARD_SB_TROUBLE = 2'd2
    } tl_state_e;

    // One cache tag, the address bits above index and offset
    typedef logic [`TL_TAG_W-1:0] dcache_tag_t;

endpackage : tl_pkg

// ==== hw/dcache_tag.sv ====
`include "tl_defines.svh"

module dcache_tag (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic [`TL_WORD_W-1:0] lookup_addr_i,
    input  logic                  fill_i,
    input  logic [`TL_WORD_W-1:0] fill_addr_i,
    output logic                  hit_o,
    output logic                  miss_o
);
    import tl_pkg::*;

    dcache_tag_t            tag_q [`TL_LINES];
    logic [`TL_LINES-1:0]   valid_q;

    logic [`TL_INDEX_W-1:0] lookup_index;
    dcache_tag_t            lookup_tag;
    logic [`TL_INDEX_W-1:0] fill_index;
    dcache_tag_t            fill_tag;

    // Split both addresses into tag and index
    assign lookup_index = lookup_addr_i[`TL_OFFSET_W +: `TL_INDEX_W];
    assign lookup_tag   = lookup_addr_i[`TL_WORD_W-1 -: `TL_TAG_W];
    assign fill_index   = fill_addr_i[`TL_OFFSET_W +: `TL_INDEX_W];
    assign fill_tag     = fill_addr_i[`TL_WORD_W-1 -: `TL_TAG_W];

    // Valid bits start empty and are set by a refill
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    // Tag storage
    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[fill_index] <= fill_tag;
        end
    end

    // Direct-mapped lookup, one way per index
    assign hit_o  = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
    assign miss_o = !hit_o;

endmodule : dcache_tag

// ==== hw/store_buffer.sv ====
`include "tl_defines.svh"

module store_buffer (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  store_req_i,
    input  logic                  load_req_i,
    input  logic                  flush_chance_i,
    input  logic [`TL_WORD_W-1:0] addr_i,
    input  logic [`TL_WORD_W-1:0] data_i,
    output logic                  hit_o,
    output logic                  trouble_o,
    output logic                  data_valid_o,
    output logic [`TL_WORD_W-1:0] data_load_o,
    output logic [`TL_WORD_W-1:0] flush_addr_o,
    output logic [`TL_WORD_W-1:0] flush_data_o
);
    localparam int PTR_W = `TL_SB_PTR_W;

    logic [`TL_SB_DEPTH-1:0] valid_q;
    logic [`TL_WORD_W-1:0]   addr_q [`TL_SB_DEPTH];
    logic [`TL_WORD_W-1:0]   data_q [`TL_SB_DEPTH];
    logic [PTR_W-1:0]        head_q;
    logic [PTR_W-1:0]        tail_q;

    logic [PTR_W-1:0]        match_idx;
    logic                    any_match;
    logic                    full;
    logic                    pop;
    logic                    push;
    logic                    merge;

    // Circular pointer advance
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`TL_SB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Word-address match against every buffered entry
    always_comb begin
        any_match = 1'b0;
        match_idx = '0;
        for (int i = 0; i < `TL_SB_DEPTH; i++) begin
            if (valid_q[i] && (addr_q[i][`TL_WORD_W-1:`TL_WORD_OFFSET_W] ==
                               addr_i[`TL_WORD_W-1:`TL_WORD_OFFSET_W])) begin
                any_match = 1'b1;
                match_idx = PTR_W'(i);
            end
        end
    end

    assign full         = &valid_q;
    assign data_valid_o = |valid_q;
    assign pop          = flush_chance_i && data_valid_o;

    // A store that cannot merge needs a slot, the one being popped counts
    assign trouble_o = full && !any_match && !pop;
    assign merge     = store_req_i && any_match;
    assign push      = store_req_i && !any_match && !trouble_o;

    assign hit_o        = load_req_i && any_match;
    assign data_load_o  = any_match ? data_q[match_idx] : '0;
    assign flush_addr_o = addr_q[head_q];
    assign flush_data_o = data_q[head_q];

    // Occupancy and pointers, a push into the popped slot wins
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (pop) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= ptr_next(head_q);
            end
            if (push) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= ptr_next(tail_q);
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        if (push) begin
            addr_q[tail_q] <= addr_i;
            data_q[tail_q] <= data_i;
        end else if (merge) begin
            data_q[match_idx] <= data_i;
        end
    end

endmodule : store_buffer

// ==== hw/tl_control.sv ====
`include "tl_defines.svh"

module tl_control (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  memop_rd_i,
    input  logic                  memop_wr_i,
    input  logic [`TL_WORD_W-1:0] addr_i,
    input  logic                  store_permission_i,
    input  logic                  mmu_data_rdy_i,
    input  logic                  cache_hit_i,
    input  logic                  cache_miss_i,
    input  logic                  sb_hit_i,
    input  logic                  sb_trouble_i,
    input  logic                  sb_data_valid_i,
    output logic                  store_req_o,
    output logic                  load_req_o,
    output logic                  flush_chance_o,
    output tl_pkg::tl_state_e     state_o,
    output logic                  pipeline_hazard_o,
    output logic                  mmu_miss_o,
    output logic [`TL_WORD_W-1:0] mmu_addr_o
);
    import tl_pkg::*;

    tl_state_e   state_q;
    tl_state_e   state_d;
    logic        load_miss;
    logic        store_block;
    logic        drain_ok;
    dcache_tag_t miss_tag;

    // Load served by neither the cache nor the buffer
    assign load_miss   = memop_rd_i && !cache_hit_i && !sb_hit_i;
    assign store_block = memop_wr_i && sb_trouble_i;

    // Stores enter the buffer only when idle, loads look it up except under store trouble
    assign store_req_o = (state_q == TL_IDLE) && memop_wr_i;
    assign load_req_o  = (state_q != HAZARD_SB_TROUBLE) && memop_rd_i;
    assign drain_ok    = store_permission_i && sb_data_valid_i;

    always_comb begin
        state_d           = state_q;
        pipeline_hazard_o = 1'b0;
        flush_chance_o    = 1'b0;
        case (state_q)
            TL_IDLE: begin
                pipeline_hazard_o = load_miss || store_block;
                flush_chance_o    = drain_ok && !memop_rd_i && !memop_wr_i;
                if (load_miss) begin
                    state_d = HAZARD_DC_MISS;
                end else if (store_block) begin
                    state_d = HAZARD_SB_TROUBLE;
                end
            end
            HAZARD_DC_MISS: begin
                pipeline_hazard_o = 1'b1;
                if (mmu_data_rdy_i) begin
                    state_d = TL_IDLE;
                end
            end
            HAZARD_SB_TROUBLE: begin
                pipeline_hazard_o = 1'b1;
                flush_chance_o    = drain_ok;
                if (!sb_trouble_i) begin
                    state_d = TL_IDLE;
                end
            end
            default: state_d = TL_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= TL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Line request toward the MMU
    assign mmu_miss_o = memop_rd_i && cache_miss_i && !sb_hit_i &&
                        ((state_q == TL_IDLE) || (state_q == HAZARD_DC_MISS));
    assign miss_tag   = addr_i[`TL_WORD_W-1 -: `TL_TAG_W];
    assign mmu_addr_o = {miss_tag, addr_i[`TL_OFFSET_W +: `TL_INDEX_W], {`TL_OFFSET_W{1'b0}}};
    assign state_o    = state_q;

endmodule : tl_control

// ==== hw/tl_stage_latch.sv ====
`include "tl_defines.svh"

module tl_stage_latch (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  stall_i,
    input  tl_pkg::tl_state_e     state_i,
    input  logic [`TL_WORD_W-1:0] addr_i,
    input  logic                  rf_we_i,
    input  logic [`TL_REG_W-1:0]  rf_waddr_i,
    input  logic                  memop_rd_i,
    input  logic                  sb_hit_i,
    input  logic [`TL_WORD_W-1:0] sb_data_load_i,
    input  logic                  flush_i,
    input  logic [`TL_WORD_W-1:0] flush_addr_i,
    input  logic [`TL_WORD_W-1:0] flush_data_i,
    output logic [`TL_WORD_W-1:0] addr_o,
    output logic                  rf_we_o,
    output logic [`TL_REG_W-1:0]  rf_waddr_o,
    output logic                  memop_rd_o,
    output logic                  memop_wr_o,
    output logic                  sb_hit_o,
    output logic [`TL_WORD_W-1:0] sb_data_load_o,
    output logic                  sb_flush_o,
    output logic [`TL_WORD_W-1:0] sb_addr_o,
    output logic [`TL_WORD_W-1:0] sb_data_flush_o
);
    import tl_pkg::*;

    logic drain;

    // Drains pass while running, and under a stall only for store trouble
    assign drain = flush_i && (!stall_i || (state_i == HAZARD_SB_TROUBLE));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            addr_o          <= '0;
            rf_we_o         <= 1'b0;
            rf_waddr_o      <= '0;
            memop_rd_o      <= 1'b0;
            memop_wr_o      <= 1'b0;
            sb_hit_o        <= 1'b0;
            sb_data_load_o  <= '0;
            sb_flush_o      <= 1'b0;
            sb_addr_o       <= '0;
            sb_data_flush_o <= '0;
        end else begin
            if (!stall_i) begin
                addr_o         <= addr_i;
                rf_we_o        <= rf_we_i;
                rf_waddr_o     <= rf_waddr_i;
                memop_rd_o     <= memop_rd_i;
                sb_hit_o       <= sb_hit_i;
                sb_data_load_o <= sb_data_load_i;
            end else begin
                // Held operation is not passed on
                rf_we_o    <= 1'b0;
                memop_rd_o <= 1'b0;
                sb_hit_o   <= 1'b0;
            end
            // The memory stage writes only drained entries
            sb_flush_o <= drain;
            memop_wr_o <= drain;
            if (drain) begin
                sb_addr_o       <= flush_addr_i;
                sb_data_flush_o <= flush_data_i;
            end
        end
    end

endmodule : tl_stage_latch

// ==== hw/tl_stage.sv ====
`include "tl_defines.svh"

module tl_stage (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic [`TL_WORD_W-1:0] addr_i,
    input  logic [`TL_WORD_W-1:0] st_data_i,
    input  logic                  rf_we_i,
    input  logic [`TL_REG_W-1:0]  rf_waddr_i,
    input  logic                  memop_rd_i,
    input  logic                  memop_wr_i,
    input  logic                  store_permission_i,
    input  logic                  mmu_data_rdy_i,
    input  logic [`TL_WORD_W-1:0] mmu_addr_i,
    output logic                  pipeline_hazard_o,
    output logic                  mmu_miss_o,
    output logic [`TL_WORD_W-1:0] mmu_addr_o,
    output logic [`TL_WORD_W-1:0] addr_o,
    output logic                  rf_we_o,
    output logic [`TL_REG_W-1:0]  rf_waddr_o,
    output logic                  memop_rd_o,
    output logic                  memop_wr_o,
    output logic                  sb_hit_o,
    output logic [`TL_WORD_W-1:0] sb_data_load_o,
    output logic                  sb_flush_o,
    output logic [`TL_WORD_W-1:0] sb_addr_o,
    output logic [`TL_WORD_W-1:0] sb_data_flush_o
);
    import tl_pkg::*;

    logic                  cache_hit;
    logic                  cache_miss;
    logic                  sb_hit;
    logic                  sb_trouble;
    logic                  sb_data_valid;
    logic [`TL_WORD_W-1:0] sb_data_load;
    logic [`TL_WORD_W-1:0] sb_flush_addr;
    logic [`TL_WORD_W-1:0] sb_flush_data;
    logic                  store_req;
    logic                  load_req;
    logic                  flush_chance;
    tl_state_e             state;

    // Refill pulse writes the tag of the returned line
    dcache_tag u_dcache_tag (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .lookup_addr_i (addr_i),
        .fill_i        (mmu_data_rdy_i),
        .fill_addr_i   (mmu_addr_i),
        .hit_o         (cache_hit),
        .miss_o        (cache_miss)
    );

    store_buffer u_store_buffer (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .store_req_i    (store_req),
        .load_req_i     (load_req),
        .flush_chance_i (flush_chance),
        .addr_i         (addr_i),
        .data_i         (st_data_i),
        .hit_o          (sb_hit),
        .trouble_o      (sb_trouble),
        .data_valid_o   (sb_data_valid),
        .data_load_o    (sb_data_load),
        .flush_addr_o   (sb_flush_addr),
        .flush_data_o   (sb_flush_data)
    );

    tl_control u_tl_control (
        .clk_i              (clk_i),
        .arst_n_i           (arst_n_i),
        .memop_rd_i         (memop_rd_i),
        .memop_wr_i         (memop_wr_i),
        .addr_i             (addr_i),
        .store_permission_i (store_permission_i),
        .mmu_data_rdy_i     (mmu_data_rdy_i),
        .cache_hit_i        (cache_hit),
        .cache_miss_i       (cache_miss),
        .sb_hit_i           (sb_hit),
        .sb_trouble_i       (sb_trouble),
        .sb_data_valid_i    (sb_data_valid),
        .store_req_o        (store_req),
        .load_req_o         (load_req),
        .flush_chance_o     (flush_chance),
        .state_o            (state),
        .pipeline_hazard_o  (pipeline_hazard_o),
        .mmu_miss_o         (mmu_miss_o),
        .mmu_addr_o         (mmu_addr_o)
    );

    // The hazard level doubles as the latch stall
    tl_stage_latch u_stage_latch (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .stall_i         (pipeline_hazard_o),
        .state_i         (state),
        .addr_i          (addr_i),
        .rf_we_i         (rf_we_i),
        .rf_waddr_i      (rf_waddr_i),
        .memop_rd_i      (memop_rd_i),
        .sb_hit_i        (sb_hit),
        .sb_data_load_i  (sb_data_load),
        .flush_i         (flush_chance),
        .flush_addr_i    (sb_flush_addr),
        .flush_data_i    (sb_flush_data),
        .addr_o          (addr_o),
        .rf_we_o         (rf_we_o),
        .rf_waddr_o      (rf_waddr_o),
        .memop_rd_o      (memop_rd_o),
        .memop_wr_o      (memop_wr_o),
        .sb_hit_o        (sb_hit_o),
        .sb_data_load_o  (sb_data_load_o),
        .sb_flush_o      (sb_flush_o),
        .sb_addr_o       (sb_addr_o),
        .sb_data_flush_o (sb_data_flush_o)
    );

endmodule : tl_stage

// ==== verif/tl_stage_checker.sv ====
`include "tl_defines.svh"

module tl_stage_checker (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  tl_pkg::tl_state_e state_i,
    input  logic              pipeline_hazard_o,
    input  logic              mmu_miss_o,
    input  logic              rf_we_o,
    input  logic              memop_rd_o,
    input  logic              memop_wr_o,
    input  logic              sb_hit_o,
    input  logic              sb_flush_o
);
    import tl_pkg::*;

    int fail_count = 0;

    // A drained entry is always written by the memory stage
    assert property (@(posedge clk_i) disable iff (!arst_n_i) sb_flush_o |-> memop_wr_o)
        else begin
            fail_count++;
            $error("sb_flush_o without memop_wr_o");
        end

    assert property (@(posedge clk_i) disable iff (!arst_n_i) pipeline_hazard_o |=> !rf_we_o)
        else begin
            fail_count++;
            $error("rf_we_o passed on after a hazard cycle");
        end

    assert property (@(posedge clk_i) disable iff (!arst_n_i) mmu_miss_o |-> pipeline_hazard_o)
        else begin
            fail_count++;
            $error("mmu_miss_o without pipeline_hazard_o");
        end

    // Reset leaves the FSM idle and every registered flag low
    assert property (@(posedge clk_i) !arst_n_i |->
                     (state_i == TL_IDLE) &&
                     !(rf_we_o || memop_rd_o || memop_wr_o || sb_hit_o || sb_flush_o))
        else begin
            fail_count++;
            $error("state or registered output not cleared during reset");
        end

endmodule : tl_stage_checker

bind tl_stage tl_stage_checker u_checker (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .state_i           (state),
    .pipeline_hazard_o (pipeline_hazard_o),
    .mmu_miss_o        (mmu_miss_o),
    .rf_we_o           (rf_we_o),
    .memop_rd_o        (memop_rd_o),
    .memop_wr_o        (memop_wr_o),
    .sb_hit_o          (sb_hit_o),
    .sb_flush_o        (sb_flush_o)
);

// ==== verif/tl_stage_monitor.sv ====
`include "tl_defines.svh"

module tl_stage_monitor (
    input  logic                  pipeline_hazard_i,
    input  logic                  mmu_miss_i,
    input  logic [`TL_WORD_W-1:0] mmu_addr_i,
    input  logic [`TL_WORD_W-1:0] addr_i,
    input  logic                  rf_we_i,
    input  logic [`TL_REG_W-1:0]  rf_waddr_i,
    input  logic                  memop_rd_i,
    input  logic                  memop_wr_i,
    input  logic                  sb_hit_i,
    input  logic [`TL_WORD_W-1:0] sb_data_load_i,
    input  logic                  sb_flush_i,
    input  logic [`TL_WORD_W-1:0] sb_addr_i,
    input  logic [`TL_WORD_W-1:0] sb_data_flush_i
);
    int errors = 0;

    task automatic compare(input string test, input string field,
                           input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Error %s %s expected %h actual %h", test, field, exp, act);
        end
    endtask

    // Levels seen in the cycle the operation is presented
    task automatic check_comb(input string test, input logic haz, input logic miss,
                              input logic [31:0] maddr);
        compare(test, "pipeline_hazard_o", haz, pipeline_hazard_i);
        compare(test, "mmu_miss_o", miss, mmu_miss_i);
        if (miss) begin
            compare(test, "mmu_addr_o", maddr, mmu_addr_i);
        end
    endtask

    // Memory-stage outputs one edge later
    task automatic check_reg(input string test, input logic rd, input logic hit,
                             input logic [31:0] ldata, input logic flush,
                             input logic [31:0] faddr, input logic [31:0] fdata,
                             input logic taken, input logic [31:0] addr,
                             input logic [4:0] waddr);
        compare(test, "memop_rd_o", rd, memop_rd_i);
        compare(test, "rf_we_o", rd, rf_we_i);
        compare(test, "sb_hit_o", hit, sb_hit_i);
        compare(test, "sb_flush_o", flush, sb_flush_i);
        compare(test, "memop_wr_o", flush, memop_wr_i);
        if (hit) begin
            compare(test, "sb_data_load_o", ldata, sb_data_load_i);
        end
        if (flush) begin
            compare(test, "sb_addr_o", faddr, sb_addr_i);
            compare(test, "sb_data_flush_o", fdata, sb_data_flush_i);
        end
        // Operand fields move only when the operation was accepted
        if (taken) begin
            compare(test, "addr_o", addr, addr_i);
            compare(test, "rf_waddr_o", waddr, rf_waddr_i);
        end
    endtask

endmodule : tl_stage_monitor

// ==== verif/tl_stage_tb.sv ====
`include "tl_defines.svh"

module tl_stage_tb;
    localparam int NUM_ROWS = 23;
    localparam int LIMIT    = NUM_ROWS * 8 + 50;

    logic        clk_i;
    logic        arst_n_i;
    logic        rf_we_i;
    logic        memop_rd_i;
    logic        memop_wr_i;
    logic        store_permission_i;
    logic        mmu_data_rdy_i;
    logic [31:0] addr_i;
    logic [31:0] st_data_i;
    logic [31:0] mmu_addr_i;
    logic [4:0]  rf_waddr_i;
    logic        pipeline_hazard_o;
    logic        mmu_miss_o;
    logic        rf_we_o;
    logic        memop_rd_o;
    logic        memop_wr_o;
    logic        sb_hit_o;
    logic        sb_flush_o;
    logic [31:0] mmu_addr_o;
    logic [31:0] addr_o;
    logic [31:0] sb_data_load_o;
    logic [31:0] sb_addr_o;
    logic [31:0] sb_data_flush_o;
    logic [4:0]  rf_waddr_o;

    integer seed;
    int     cycles;
    logic [31:0] rnd_data [8];

    // Operation 0 idle, 1 load, 2 store; data fields index rnd_data
    string       t_name [NUM_ROWS];
    int          t_op [NUM_ROWS];
    logic [31:0] t_addr [NUM_ROWS];
    int          t_dsel [NUM_ROWS];
    logic        t_perm [NUM_ROWS];
    logic        t_refill [NUM_ROWS];
    logic        t_stall [NUM_ROWS];
    logic        e_haz [NUM_ROWS];
    logic        e_miss [NUM_ROWS];
    logic        e_rd [NUM_ROWS];
    logic        e_hit [NUM_ROWS];
    int          e_lsel [NUM_ROWS];
    logic        e_flush [NUM_ROWS];
    logic [31:0] e_faddr [NUM_ROWS];
    int          e_fsel [NUM_ROWS];

    tl_stage u_dut (.*);

    tl_stage_monitor u_mon (
        .pipeline_hazard_i (pipeline_hazard_o), .mmu_miss_i (mmu_miss_o),
        .mmu_addr_i (mmu_addr_o), .addr_i (addr_o), .rf_we_i (rf_we_o),
        .rf_waddr_i (rf_waddr_o), .memop_rd_i (memop_rd_o), .memop_wr_i (memop_wr_o),
        .sb_hit_i (sb_hit_o), .sb_data_load_i (sb_data_load_o), .sb_flush_i (sb_flush_o),
        .sb_addr_i (sb_addr_o), .sb_data_flush_i (sb_data_flush_o)
    );

    task automatic set_row(input int i, input string name, input int op, input logic [31:0] a,
                           input int dsel, input logic perm, input logic refill,
                           input logic stall, input logic haz, input logic miss,
                           input logic rd, input logic hit, input int lsel,
                           input logic flush, input logic [31:0] fa, input int fsel);
        t_name[i]   = name;
        t_op[i]     = op;
        t_addr[i]   = a;
        t_dsel[i]   = dsel;
        t_perm[i]   = perm;
        t_refill[i] = refill;
        t_stall[i]  = stall;
        e_haz[i]    = haz;
        e_miss[i]   = miss;
        e_rd[i]     = rd;
        e_hit[i]    = hit;
        e_lsel[i]   = lsel;
        e_flush[i]  = flush;
        e_faddr[i]  = fa;
        e_fsel[i]   = fsel;
    endtask

    task automatic fill_table();
        set_row(0,  "reset_idle",     0, 32'h0,   0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0,   0);
        set_row(1,  "load_miss",      1, 32'h100, 0, 0, 0, 1, 1, 1, 0, 0, 0, 0, 32'h0,   0);
        set_row(2,  "refill",         1, 32'h100, 0, 0, 1, 1, 1, 1, 0, 0, 0, 0, 32'h0,   0);
        set_row(3,  "load_done",      1, 32'h100, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 32'h0,   0);
        set_row(4,  "load_again",     1, 32'h108, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 32'h0,   0);
        set_row(5,  "store_a",        2, 32'h200, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0,   0);
        set_row(6,  "fwd_a",          1, 32'h200, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 32'h0,   0);
        set_row(7,  "drain_a",        0, 32'h0,   0, 1, 0, 0, 0, 0, 0, 0, 0, 1, 32'h200, 0);
        set_row(8,  "drain_empty",    0, 32'h0,   0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0,   0);
        set_row(9,  "store_b",        2, 32'h300, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0,   0);
        set_row(10, "merge_b",        2, 32'h300, 2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0,   0);
        set_row(11, "fwd_b",          1, 32'h300, 0, 0, 0, 0, 0, 0, 1, 1, 2, 0, 32'h0,   0);
        set_row(12, "drain_b",        0, 32'h0,   0, 1, 0, 0, 0, 0, 0, 0, 0, 1, 32'h300, 2);
        set_row(13, "drain_b_once",   0, 32'h0,   0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0,   0);
        set_row(14, "store_c",        2, 32'h400, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0,   0);
        set_row(15, "store_d",        2, 32'h500, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0,   0);
        set_row(16, "store_full",     2, 32'h600, 5, 0, 0, 1, 1, 0, 0, 0, 0, 0, 32'h0,   0);
        set_row(17, "full_hold",      2, 32'h600, 5, 0, 0, 1, 1, 0, 0, 0, 0, 0, 32'h0,   0);
        set_row(18, "full_drain",     2, 32'h600, 5, 1, 0, 1, 1, 0, 0, 0, 0, 1, 32'h400, 3);
        set_row(19, "full_accept",    2, 32'h600, 5, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0,   0);
        set_row(20, "idle_drain_1",   0, 32'h0,   0, 1, 0, 0, 0, 0, 0, 0, 0, 1, 32'h500, 4);
        set_row(21, "idle_drain_2",   0, 32'h0,   0, 1, 0, 0, 0, 0, 0, 0, 0, 1, 32'h600, 5);
        set_row(22, "idle_drain_end", 0, 32'h0,   0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0,   0);
    endtask

    task automatic drive_idle();
        memop_rd_i         <= 1'b0;
        memop_wr_i         <= 1'b0;
        rf_we_i            <= 1'b0;
        addr_i             <= '0;
        store_permission_i <= 1'b0;
        mmu_data_rdy_i     <= 1'b0;
    endtask

    // Compare the latched outputs that row j produced
    task automatic verify_latched(input int j);
        u_mon.check_reg(t_name[j], e_rd[j], e_hit[j], rnd_data[e_lsel[j]], e_flush[j],
                        e_faddr[j], rnd_data[e_fsel[j]], !t_stall[j], t_addr[j], 5'(j));
    endtask

    // One row per cycle with latched results compared one edge later
    task automatic run_rows();
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk_i);
            memop_rd_i         <= (t_op[i] == 1);
            memop_wr_i         <= (t_op[i] == 2);
            rf_we_i            <= (t_op[i] == 1);
            rf_waddr_i         <= 5'(i);
            addr_i             <= t_addr[i];
            st_data_i          <= rnd_data[t_dsel[i]];
            store_permission_i <= t_perm[i];
            mmu_data_rdy_i     <= t_refill[i];
            mmu_addr_i         <= t_addr[i] & ~32'hF;
            @(negedge clk_i);
            if (i > 0) begin
                verify_latched(i - 1);
            end
            u_mon.check_comb(t_name[i], e_haz[i], e_miss[i], t_addr[i] & ~32'hF);
            if (!t_stall[i]) begin
                while (pipeline_hazard_o) begin
                    @(negedge clk_i);
                end
            end
        end
        @(posedge clk_i);
        drive_idle();
        @(negedge clk_i);
        verify_latched(NUM_ROWS - 1);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Run limit derived from the table length
    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", LIMIT);
        $display("sim failed");
        $finish;
    end

    initial begin
        seed = 32'h486c8d97;
        for (int k = 0; k < 8; k++) begin
            rnd_data[k] = $random(seed);
        end
        fill_table();
        arst_n_i   = 1'b0;
        st_data_i  = '0;
        rf_waddr_i = '0;
        mmu_addr_i = '0;
        memop_rd_i = 1'b0;
        memop_wr_i = 1'b0;
        rf_we_i    = 1'b0;
        addr_i     = '0;
        store_permission_i = 1'b0;
        mmu_data_rdy_i     = 1'b0;
        repeat (2) @(posedge clk_i);
        // Outputs while reset is still held
        @(negedge clk_i);
        u_mon.check_comb("reset", 1'b0, 1'b0, '0);
        u_mon.check_reg("reset", 1'b0, 1'b0, '0, 1'b0, '0, '0, 1'b1, '0, '0);
        @(posedge clk_i);
        arst_n_i <= 1'b1;
        run_rows();
        $display("Check errors: %0d, assertion failures: %0d", u_mon.errors,
                 u_dut.u_checker.fail_count);
        if ((u_mon.errors == 0) && (u_dut.u_checker.fail_count == 0)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : tl_stage_tb

// ==== files.f ====
+incdir+hw
hw/tl_pkg.sv
hw/dcache_tag.sv
hw/store_buffer.sv
hw/tl_control.sv
hw/tl_stage_latch.sv
hw/tl_stage.sv
verif/tl_stage_checker.sv
verif/tl_stage_monitor.sv
verif/tl_stage_tb.sv
